// ==== tb.f ====
source/aer_geom_pkg.sv
source/arb_ctrl_pkg.sv
source/rr_arb_if.sv
source/aer_event_if.sv
source/round_robin_arbiter.sv
source/pixel_scan_ctrl.sv
source/aer_event_packer.sv
source/pixel_array_aer_top.sv
dv/tb_pixel_array_aer.sv

// ==== Makefile ====
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -Wno-fatal
TOP       := tb_pixel_array_aer
FILELIST  := tb.f
OBJ_DIR   := obj_dir
SIM_BIN   := $(OBJ_DIR)/V$(TOP)
PASS_MSG  := All tests passed
SOURCES   := $(shell cat $(FILELIST))

.PHONY: all run clean

all: run

# Rebuilt only when a source or the file list changes
$(SIM_BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR) -o V$(TOP)

run: $(SIM_BIN)
	@out="$$($(SIM_BIN))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)

// ==== dv/tb_pixel_array_aer.sv ====
// ################################################
// Testbench for the pixel array readout: clock, reset,
// pixel model, event monitor, watchdog, directed tests
// ################################################

`timescale 1ns/10ps

module tb_pixel_array_aer;

    localparam int ROWS       = aer_geom_pkg::DEF_ROWS;
    localparam int COLS       = aer_geom_pkg::DEF_COLS;
    localparam int TS_WIDTH   = aer_geom_pkg::DEF_TS_WIDTH;
    localparam int PCW        = aer_geom_pkg::PIX_CODE_W;
    localparam int NPIX       = ROWS * COLS;
    localparam int RA_W       = (ROWS > 1) ? $clog2(ROWS) : 1;
    localparam int CA_W       = (COLS > 1) ? $clog2(COLS) : 1;
    localparam int EVT_W      = RA_W + CA_W + 1 + TS_WIDTH;
    localparam int CMP_W      = (NPIX > EVT_W) ? ((NPIX > 32) ? NPIX : 32)
                                               : ((EVT_W > 32) ? EVT_W : 32);
    localparam int CLK_PERIOD = 100;
    localparam int DRAIN_MAX  = NPIX + 2 * ROWS + 20;          // Full array plus row overhead
    localparam int WD_CYCLES  = 6 * (NPIX + ROWS + 20);         // Six tests, worst case each

    logic                clk_i;
    logic                reset_i;
    logic                enable_i;
    logic [PCW*NPIX-1:0] req_i;                                 // Pixel model state
    logic [NPIX-1:0]     gnt_o;
    logic                event_valid_o;
    logic [EVT_W-1:0]    event_o;

    logic [31:0]         edge_cnt;                              // Rising edges since reset
    int                  err_count    = 0;
    int                  check_count  = 0;
    int                  tests_failed = 0;
    integer              seed;
    logic [PCW-1:0]      exp_code [NPIX];                       // Codes a test put on the array
    int                  ev_pix [$];                            // Event log, pixel index
    logic                ev_pol [$];
    logic [31:0]         ev_cyc [$];                            // Edge count of each event

    pixel_array_aer_top #(.ROWS(ROWS), .COLS(COLS), .TS_WIDTH(TS_WIDTH)) dut0
    (
        .clk_i         (clk_i),
        .reset_i       (reset_i),
        .enable_i      (enable_i),
        .req_i         (req_i),
        .gnt_o         (gnt_o),
        .event_valid_o (event_valid_o),
        .event_o       (event_o)
    );

    initial
    begin
        clk_i = 1'b0;
        forever #(CLK_PERIOD / 2) clk_i = ~clk_i;
    end

    always @(posedge clk_i or posedge reset_i)
    begin
        if (reset_i)
        begin
            edge_cnt <= '0;
        end
        else
        begin
            edge_cnt <= edge_cnt + 32'd1;
        end
    end

    // Pixel drops its code on the falling edge after its grant
    always @(negedge clk_i)
    begin
        for (int p = 0; p < NPIX; p++)
        begin
            if (gnt_o[p])
            begin
                req_i[PCW*p +: PCW] = '0;
            end
        end
    end

    // Sample a quarter period after each rising edge while granted codes are still up
    initial
    begin
        forever
        begin
            @(posedge clk_i);
            #(CLK_PERIOD / 4);
            sample_outputs();
        end
    end

    initial
    begin
        repeat (WD_CYCLES) @(posedge clk_i);
        $display("Watchdog: run timed out after %0d cycles", WD_CYCLES);
        $display("Some tests failed");
        $finish;
    end

    task automatic check_value(input logic [CMP_W-1:0] actual, input logic [CMP_W-1:0] expected,
                               input string what);
        check_count++;
        if (actual !== expected)
        begin
            err_count++;
            $display("MISMATCH at %0t: %s, got %0h expected %0h", $time, what, actual, expected);
        end
    endtask

    task automatic sample_outputs();
        int                  pix;
        logic [TS_WIDTH-1:0] ts;
        logic [CMP_W-1:0]    one_hot;
        if (event_valid_o)
        begin
            pix = int'(event_o[EVT_W-1 -: RA_W]) * COLS       // Row field
                + int'(event_o[EVT_W-RA_W-1 -: CA_W]);         // Column field
            ts  = event_o[TS_WIDTH-1:0];
            one_hot = '0;
            one_hot[pix] = 1'b1;
            check_value(CMP_W'(gnt_o), one_hot, "gnt_o not one-hot at event address");
            check_value(CMP_W'(ts), CMP_W'(edge_cnt[TS_WIDTH-1:0]), "event timestamp");
            check_value(CMP_W'(req_i[PCW*pix +: PCW] != '0), CMP_W'(1), "event on idle pixel");
            ev_pix.push_back(pix);
            ev_pol.push_back(event_o[TS_WIDTH]);
            ev_cyc.push_back(edge_cnt);
        end
        else
        begin
            check_value(CMP_W'(gnt_o), '0, "gnt_o high without event");
            check_value(CMP_W'(event_o), '0, "event_o nonzero without event");
        end
    endtask

    // Loads exp_code onto the array and raises enable, grants are all low here
    task automatic start_scan();
        ev_pix.delete();
        ev_pol.delete();
        ev_cyc.delete();
        @(negedge clk_i);
        for (int p = 0; p < NPIX; p++)
        begin
            req_i[PCW*p +: PCW] = exp_code[p];
        end
        enable_i = 1'b1;
    endtask

    task automatic finish_scan(input string name);
        int cycles;
        cycles = 0;
        while (req_i != '0 && cycles < DRAIN_MAX)
        begin
            @(posedge clk_i);
            cycles++;
        end
        if (req_i != '0)
        begin
            err_count++;
            $display("%s: pixel requests still pending after %0d cycles", name, DRAIN_MAX);
        end
        @(negedge clk_i);
        enable_i = 1'b0;
        repeat (2) @(negedge clk_i);
    endtask

    // One event per requesting pixel, polarity ON when the ON bit is set
    task automatic check_events(input string name, input bit rows_contiguous);
        bit   seen [NPIX];
        bit   row_left [ROWS];
        int   n_exp;
        int   row;
        int   prev_row;
        logic pol_exp;
        n_exp    = 0;
        prev_row = -1;
        for (int p = 0; p < NPIX; p++)
        begin
            seen[p] = 1'b0;
            n_exp  += (exp_code[p] != 2'b00) ? 1 : 0;
        end
        for (int r = 0; r < ROWS; r++)
        begin
            row_left[r] = 1'b0;
        end
        check_value(CMP_W'(ev_pix.size()), CMP_W'(n_exp), {name, ": event count"});
        foreach (ev_pix[i])
        begin
            row     = ev_pix[i] / COLS;
            pol_exp = (exp_code[ev_pix[i]] == 2'b01) || (exp_code[ev_pix[i]] == 2'b11);
            check_value(CMP_W'(exp_code[ev_pix[i]] != 2'b00), CMP_W'(1),
                        {name, ": event on pixel without request"});
            check_value(CMP_W'(seen[ev_pix[i]]), '0, {name, ": pixel delivered twice"});
            check_value(CMP_W'(ev_pol[i]), CMP_W'(pol_exp), {name, ": polarity"});
            seen[ev_pix[i]] = 1'b1;
            if (rows_contiguous)
            begin
                if (prev_row >= 0 && row != prev_row)
                begin
                    row_left[prev_row] = 1'b1;                  // Row closed for good
                end
                check_value(CMP_W'(row_left[row]), '0, {name, ": row events split"});
                prev_row = row;
            end
        end
    endtask

    task automatic report_test(input int num, input string name, input int errs_before);
        if (err_count == errs_before)
        begin
            $display("Test %0d %s: ok", num, name);
        end
        else
        begin
            tests_failed++;
            $display("Test %0d %s: FAILED, %0d errors", num, name, err_count - errs_before);
        end
    endtask

    task automatic clear_expect();
        for (int p = 0; p < NPIX; p++)
        begin
            exp_code[p] = 2'b00;
        end
    endtask

    task automatic test_idle(input int num);
        int errs;
        errs = err_count;
        ev_pix.delete();
        @(posedge clk_i);
        #(CLK_PERIOD / 4);
        check_value(CMP_W'(event_valid_o), '0, "event_valid_o after reset");
        @(negedge clk_i);
        req_i[0 +: PCW]            = 2'b01;                     // Opposite corners
        req_i[PCW*(NPIX-1) +: PCW] = 2'b11;
        repeat (10) @(negedge clk_i);
        check_value(CMP_W'(ev_pix.size()), '0, "events with enable_i low");
        req_i = '0;
        @(negedge clk_i);
        report_test(num, "idle after reset", errs);
    endtask

    task automatic test_single_on(input int num);
        int errs;
        int pix;
        errs = err_count;
        pix  = (ROWS / 2 - 1) * COLS + (COLS - 3);
        clear_expect();
        exp_code[pix] = 2'b01;
        start_scan();
        finish_scan("single ON");
        check_events("single ON", 1'b1);
        if (ev_pix.size() > 0)
        begin
            check_value(CMP_W'(ev_pix[0] / COLS), CMP_W'(ROWS / 2 - 1), "single ON row");
            check_value(CMP_W'(ev_pix[0] % COLS), CMP_W'(COLS - 3), "single ON column");
        end
        report_test(num, "single ON pixel", errs);
    endtask

    task automatic test_polarity(input int num);
        int errs;
        errs = err_count;
        clear_expect();
        exp_code[1 * COLS + 2]    = 2'b10;                      // OFF only
        exp_code[(ROWS - 2) * COLS] = 2'b11;                    // Both bits, ON expected
        start_scan();
        finish_scan("polarity");
        check_events("polarity", 1'b1);
        report_test(num, "polarity rule", errs);
    endtask

    task automatic test_full_row(input int num);
        int errs;
        errs = err_count;
        clear_expect();
        for (int c = 0; c < COLS; c++)
        begin
            exp_code[(ROWS / 2) * COLS + c] = (c % 2 == 0) ? 2'b01 : 2'b10;
        end
        start_scan();
        finish_scan("full row");
        check_events("full row", 1'b1);
        foreach (ev_cyc[i])
        begin
            check_value(CMP_W'(ev_cyc[i] - ev_cyc[0]), CMP_W'(i), "full row cycle spacing");
        end
        report_test(num, "full row", errs);
    endtask

    task automatic test_scatter(input int num);
        int          errs;
        logic [31:0] rnd;
        errs = err_count;
        for (int p = 0; p < NPIX; p++)
        begin
            rnd         = $random(seed);
            exp_code[p] = rnd[1:0];                             // About three in four request
        end
        start_scan();
        finish_scan("scatter");
        check_events("scatter", 1'b1);
        report_test(num, "random scatter", errs);
    endtask

    task automatic test_enable_drop(input int num);
        int          errs;
        int          held;
        int          cycles;
        logic [31:0] rnd;
        errs   = err_count;
        cycles = 0;
        for (int p = 0; p < NPIX; p++)
        begin
            rnd         = $random(seed);
            exp_code[p] = (rnd[1:0] == 2'b00) ? 2'b01 : rnd[1:0];   // Every pixel requests
        end
        start_scan();
        while (ev_pix.size() < NPIX / 2 - 3 && cycles < DRAIN_MAX)  // Stop partway into a row
        begin
            @(negedge clk_i);
            cycles++;
        end
        if (ev_pix.size() < NPIX / 2 - 3)
        begin
            err_count++;
            $display("enable drop: too few events before dropping enable_i");
        end
        enable_i = 1'b0;
        held     = ev_pix.size();
        repeat (10) @(negedge clk_i);
        check_value(CMP_W'(ev_pix.size()), CMP_W'(held), "events while enable_i low");
        enable_i = 1'b1;
        finish_scan("enable drop");
        check_events("enable drop", 1'b0);                      // Revisited row may split
        report_test(num, "enable drop", errs);
    endtask

    initial
    begin
        reset_i  = 1'b1;
        enable_i = 1'b0;
        req_i    = '0;
        seed     = 32'hf18d_01f5;
        clear_expect();
        repeat (4) @(posedge clk_i);
        @(negedge clk_i);
        reset_i = 1'b0;
        test_idle(1);
        test_single_on(2);
        test_polarity(3);
        test_full_row(4);
        test_scatter(5);
        test_enable_drop(6);
        $display("Tests run: 6, failed: %0d, checks: %0d, errors: %0d",
                 tests_failed, check_count, err_count);
        if (err_count == 0)
        begin
            $display("All tests passed");
        end
        else
        begin
            $display("Some tests failed");
        end
        $finish;
    end

endmodule

// ==== source/pixel_array_aer_top.sv ====
// ################################################
// Pixel array readout top, scan controller
// and event packer
// ################################################

`timescale 1ns/10ps

module pixel_array_aer_top #(
    parameter int  ROWS     = aer_geom_pkg::DEF_ROWS,     // Pixel rows
    parameter int  COLS     = aer_geom_pkg::DEF_COLS,     // Pixel columns
    parameter int  TS_WIDTH = aer_geom_pkg::DEF_TS_WIDTH, // Timestamp width
    localparam int RA_W     = (ROWS > 1) ? $clog2(ROWS) : 1,
    localparam int CA_W     = (COLS > 1) ? $clog2(COLS) : 1,
    localparam int EVT_W    = RA_W + CA_W + 1 + TS_WIDTH,
    localparam int REQ_W    = aer_geom_pkg::PIX_CODE_W * ROWS * COLS
) (
    input  logic                 clk_i,             // Clock
    input  logic                 reset_i,           // Async reset, active high
    input  logic                 enable_i,          // Readout enable level
    input  logic [REQ_W-1:0]     req_i,             // Two bits per pixel, (r,c) at r*COLS+c
    output logic [ROWS*COLS-1:0] gnt_o,             // One-hot pixel grant
    output logic                 event_valid_o,     // Event strobe
    output logic [EVT_W-1:0]     event_o            // {row, col, polarity, timestamp}
);

    aer_event_if #(.ROWS(ROWS), .COLS(COLS)) evt_if ();

    pixel_scan_ctrl #(.ROWS(ROWS), .COLS(COLS)) scan0
    (
        .clk_i    (clk_i),
        .reset_i  (reset_i),
        .enable_i (enable_i),
        .req_i    (req_i),
        .gnt_o    (gnt_o),
        .evt_o    (evt_if.src)
    );

    aer_event_packer #(.ROWS(ROWS), .COLS(COLS), .TS_WIDTH(TS_WIDTH)) pack0
    (
        .clk_i         (clk_i),
        .reset_i       (reset_i),
        .evt_i         (evt_if.snk),
        .event_valid_o (event_valid_o),
        .event_o       (event_o)
    );

endmodule

// ==== source/aer_event_packer.sv ====
// ################################################
// Timestamp counter, polarity select and
// address-event word assembly
// ################################################

`timescale 1ns/10ps

module aer_event_packer #(
    parameter int  ROWS     = 8,                    // Pixel rows
    parameter int  COLS     = 8,                    // Pixel columns
    parameter int  TS_WIDTH = 16,                   // Timestamp width
    localparam int RA_W     = (ROWS > 1) ? $clog2(ROWS) : 1,
    localparam int CA_W     = (COLS > 1) ? $clog2(COLS) : 1,
    localparam int EVT_W    = RA_W + CA_W + 1 + TS_WIDTH
) (
    input  logic             clk_i,                 // Clock
    input  logic             reset_i,               // Async reset, active high
    aer_event_if.snk         evt_i,                 // Granted pixel from controller
    output logic             event_valid_o,         // Event strobe
    output logic [EVT_W-1:0] event_o                // {row, col, polarity, timestamp}
);

    logic [TS_WIDTH-1:0]     ts_q;                  // Free-running wall clock
    aer_geom_pkg::polarity_e pol;                   // Event polarity

    // Counts rising edges since reset, wraps silently
    always_ff @(posedge clk_i or posedge reset_i)
    begin
        if (reset_i)
        begin
            ts_q <= '0;
        end
        else
        begin
            ts_q <= ts_q + 1'b1;
        end
    end

    // ON bit has priority, PIX_BOTH reports ON
    assign pol = evt_i.pix_code[aer_geom_pkg::PIX_ON_BIT] ? aer_geom_pkg::POL_ON
                                                         : aer_geom_pkg::POL_OFF;

    assign event_valid_o = evt_i.valid;

    // Word held at zero between events
    always_comb
    begin
        if (evt_i.valid)
        begin
            event_o = {evt_i.x_addr, evt_i.y_addr, pol, ts_q};
        end
        else
        begin
            event_o = '0;
        end
    end

endmodule

// ==== source/pixel_scan_ctrl.sv ====
// ################################################
// Row/column scan FSM with row and column arbiters,
// request reduction and pixel grant matrix
// ################################################

`timescale 1ns/10ps

module pixel_scan_ctrl #(
    parameter int ROWS = 8,                         // Pixel rows
    parameter int COLS = 8                          // Pixel columns
) (
    input  logic                                        clk_i,    // Clock
    input  logic                                        reset_i,  // Async reset, active high
    input  logic                                        enable_i, // Readout enable level
    input  logic [aer_geom_pkg::PIX_CODE_W*ROWS*COLS-1:0] req_i,  // Pixel codes, (r,c) at r*COLS+c
    output logic [ROWS*COLS-1:0]                        gnt_o,    // One-hot pixel grant
    aer_event_if.src                                    evt_o     // Granted pixel to packer
);

    localparam int PCW = aer_geom_pkg::PIX_CODE_W;

    arb_ctrl_pkg::scan_state_e state_q;             // Current scan state
    arb_ctrl_pkg::scan_state_e state_next;

    logic [ROWS-1:0]         row_req;               // Row has any pending pixel
    logic [COLS-1:0]         col_req;               // Pending pixels of granted row
    logic                    row_en;                // Row arbiter update
    logic                    col_en;                // Column arbiter update
    logic                    valid;                 // Pixel granted this cycle
    aer_geom_pkg::pix_code_e pix_code;              // Code of granted pixel

    rr_arb_if #(.N(ROWS)) row_if ();
    rr_arb_if #(.N(COLS)) col_if ();

    round_robin_arbiter #(.N(ROWS)) row_arb0
    (
        .clk_i   (clk_i),
        .reset_i (reset_i),
        .arb_if  (row_if.arb)
    );

    round_robin_arbiter #(.N(COLS)) col_arb0
    (
        .clk_i   (clk_i),
        .reset_i (reset_i),
        .arb_if  (col_if.arb)
    );

    // OR of every code bit in a row
    always_comb
    begin
        for (int r = 0; r < ROWS; r++)
        begin
            row_req[r] = |req_i[PCW*r*COLS +: PCW*COLS];
        end
    end

    // Columns of the row the row arbiter holds
    always_comb
    begin
        for (int c = 0; c < COLS; c++)
        begin
            col_req[c] = |req_i[PCW*(int'(row_if.idx)*COLS + c) +: PCW];
        end
    end

    assign pix_code = aer_geom_pkg::pix_code_e'(
        req_i[PCW*(int'(row_if.idx)*COLS + int'(col_if.idx)) +: PCW]);

    assign row_if.req    = row_req;
    assign col_if.req    = col_req;
    assign row_if.enable = row_en;
    assign col_if.enable = col_en;

    always_ff @(posedge clk_i or posedge reset_i)
    begin
        if (reset_i)
        begin
            state_q <= arb_ctrl_pkg::SCAN_IDLE;
        end
        else
        begin
            state_q <= state_next;
        end
    end

    // Enables go high in the cycle that decides the move
    always_comb
    begin
        state_next = state_q;
        row_en     = 1'b0;
        col_en     = 1'b0;
        if (!enable_i)
        begin
            state_next = arb_ctrl_pkg::SCAN_IDLE;   // Both arbiters freeze
        end
        else
        begin
            case (state_q)
                arb_ctrl_pkg::SCAN_IDLE:
                begin
                    row_en     = 1'b1;              // Pick a row on the way in
                    state_next = arb_ctrl_pkg::SCAN_ROW;
                end
                arb_ctrl_pkg::SCAN_ROW:
                begin
                    if (|row_if.gnt)
                    begin
                        col_en     = 1'b1;          // First column of new row
                        state_next = arb_ctrl_pkg::SCAN_COL;
                    end
                    else
                    begin
                        row_en = 1'b1;              // Keep polling rows
                    end
                end
                arb_ctrl_pkg::SCAN_COL:
                begin
                    if (|col_if.gnt)
                    begin
                        col_en = 1'b1;              // Next column each cycle
                    end
                    else
                    begin
                        row_en     = 1'b1;          // Row drained
                        state_next = arb_ctrl_pkg::SCAN_ROW;
                    end
                end
                default:
                begin
                    state_next = arb_ctrl_pkg::SCAN_IDLE;
                end
            endcase
        end
    end

    assign valid = (state_q == arb_ctrl_pkg::SCAN_COL) && (|col_if.gnt);

    // Single grant bit at (row idx, col idx)
    always_comb
    begin
        gnt_o = '0;
        if (valid)
        begin
            gnt_o[int'(row_if.idx)*COLS + int'(col_if.idx)] = 1'b1;
        end
    end

    assign evt_o.valid    = valid;
    assign evt_o.x_addr   = row_if.idx;
    assign evt_o.y_addr   = col_if.idx;
    assign evt_o.pix_code = pix_code;

    a_state_legal: assert property (@(posedge clk_i) disable iff (reset_i)
        state_q inside {arb_ctrl_pkg::SCAN_IDLE, arb_ctrl_pkg::SCAN_ROW,
                        arb_ctrl_pkg::SCAN_COL})
        else $error("pixel_scan_ctrl: illegal scan state");

    // Checked mid-cycle, the pixel drops its code at the falling edge
    a_valid_code: assert property (@(negedge clk_i) disable iff (reset_i)
        valid |-> (pix_code != aer_geom_pkg::PIX_NONE))
        else $error("pixel_scan_ctrl: grant on a pixel with no request");

endmodule

// ==== source/round_robin_arbiter.sv ====
// ################################################
// Registered round-robin arbiter, rotating
// priority pointer and binary grant index
// ################################################

`timescale 1ns/10ps

module round_robin_arbiter #(
    parameter int N = 8                             // Number of requesters
) (
    input  logic   clk_i,                           // Clock
    input  logic   reset_i,                         // Async reset, active high
    rr_arb_if.arb  arb_if                           // Enable/request in, grant/index out
);

    localparam int IDX_W = (N > 1) ? $clog2(N) : 1;

    logic [N-1:0]     gnt_q;                        // Current grant
    logic [N-1:0]     gnt_next;                     // Grant chosen for next edge
    logic [IDX_W-1:0] ptr_q;                        // Highest priority requester
    logic [IDX_W-1:0] ptr_next;                     // Pointer after this pick
    logic [IDX_W-1:0] idx_enc;                      // Encoded grant

    // Search starts at the pointer and wraps around
    always_comb
    begin
        int  cand;
        logic found;
        gnt_next = '0;
        ptr_next = ptr_q;                           // Hold pointer when nobody asks
        found    = 1'b0;
        for (int i = 0; i < N; i++)
        begin
            cand = (int'(ptr_q) + i) % N;
            if (!found && arb_if.req[cand])
            begin
                found          = 1'b1;
                gnt_next[cand] = 1'b1;
                ptr_next       = IDX_W'((cand + 1) % N); // One past the winner
            end
        end
    end

    always_ff @(posedge clk_i or posedge reset_i)
    begin
        if (reset_i)
        begin
            gnt_q <= '0;
            ptr_q <= '0;
        end
        else if (arb_if.enable)
        begin
            gnt_q <= gnt_next;                      // Zero when no request
            ptr_q <= ptr_next;
        end
    end

    // One-hot to binary
    always_comb
    begin
        idx_enc = '0;
        for (int i = 0; i < N; i++)
        begin
            if (gnt_q[i])
            begin
                idx_enc = IDX_W'(i);
            end
        end
    end

    assign arb_if.gnt = gnt_q;
    assign arb_if.idx = idx_enc;

    // Never more than one winner
    a_gnt_onehot: assert property (@(posedge clk_i) disable iff (reset_i)
        $onehot0(gnt_q))
        else $error("round_robin_arbiter: grant not one-hot");

endmodule

// ==== source/aer_event_if.sv ====
// ################################################
// Granted pixel address and code to the packer
// ################################################

`timescale 1ns/10ps

interface aer_event_if #(
    parameter int ROWS = 8,                         // Pixel rows
    parameter int COLS = 8                          // Pixel columns
);

    localparam int RA_W = (ROWS > 1) ? $clog2(ROWS) : 1; // Row address width
    localparam int CA_W = (COLS > 1) ? $clog2(COLS) : 1; // Column address width

    logic                    valid;                 // Pixel granted this cycle
    logic [RA_W-1:0]         x_addr;                // Row address
    logic [CA_W-1:0]         y_addr;                // Column address
    aer_geom_pkg::pix_code_e pix_code;              // Request code of granted pixel

    modport src (output valid, output x_addr, output y_addr, output pix_code);
    modport snk (input valid, input x_addr, input y_addr, input pix_code);

endinterface

// ==== source/rr_arb_if.sv ====
// ################################################
// Controller to round-robin arbiter bundle
// ################################################

`timescale 1ns/10ps

interface rr_arb_if #(
    parameter int N = 8                             // Number of requesters
);

    localparam int IDX_W = (N > 1) ? $clog2(N) : 1; // Binary index width

    logic             enable;                       // Arbiter may update its grant
    logic [N-1:0]     req;                          // One bit per requester
    logic [N-1:0]     gnt;                          // Registered grant, one-hot or zero
    logic [IDX_W-1:0] idx;                          // Binary form of gnt

    modport ctrl (output enable, output req, input gnt, input idx);
    modport arb  (input enable, input req, output gnt, output idx);

endinterface

// ==== source/arb_ctrl_pkg.sv ====
// ################################################
// Scan controller state encoding
// ################################################

package arb_ctrl_pkg;

    // Two-step scan, one row then its columns
    typedef enum logic [1:0]
    {
        SCAN_IDLE = 2'b00,                          // Readout disabled
        SCAN_ROW  = 2'b01,                          // Row arbiter picking next row
        SCAN_COL  = 2'b10                           // Column arbiter draining granted row
    } scan_state_e;

    // Encoding 2'b11 is never used, the FSM
    // falls back to idle if it ever shows up

endpackage

// ==== source/aer_geom_pkg.sv ====
// ################################################
// Pixel array geometry defaults, pixel request
// codes and event polarity type
// ################################################

package aer_geom_pkg;

    // Default array size, overridden at the top level
    parameter int DEF_ROWS     = 8;                 // Pixel rows
    parameter int DEF_COLS     = 8;                 // Pixel columns
    parameter int DEF_TS_WIDTH = 16;                // Timestamp counter width

    parameter int PIX_CODE_W   = 2;                 // Request bits per pixel
    parameter int PIX_ON_BIT   = 0;                 // Position of the ON event bit

    // Per-pixel request code, ON in bit 0 and OFF in bit 1
    typedef enum logic [PIX_CODE_W-1:0]
    {
        PIX_NONE = 2'b00,                           // No pending event
        PIX_ON   = 2'b01,                           // Brightness increase
        PIX_OFF  = 2'b10,                           // Brightness decrease
        PIX_BOTH = 2'b11                            // Both seen, reported as ON
    } pix_code_e;

    // Polarity bit in the address-event word
    // ON wins whenever the ON bit is set
    typedef enum logic
    {
        POL_OFF = 1'b0,                             // OFF event
        POL_ON  = 1'b1                              // ON event
    } polarity_e;

endpackage
